//--- logic/memBusPkg.sv
`default_nettype none

package memBusPkg;

    // RAM side widths
    localparam int addrW = 32;
    localparam int byteW = 8;
    localparam int wordW = 32;
    localparam int bytesPerWord = wordW / byteW;

    typedef logic [addrW-1:0] addrT;
    typedef logic [byteW-1:0] byteT;
    typedef logic [wordW-1:0] wordT;

    // who owns the RAM, same code on both wait outputs
    typedef logic [1:0] waitT;

    localparam waitT waitFree  = 2'b00;
    localparam waitT waitData  = 2'b01;
    localparam waitT waitFetch = 2'b10;

    // RAM direction
    typedef logic rwT;

    localparam rwT memRead  = 1'b0;
    localparam rwT memWrite = 1'b1;

endpackage

`default_nettype wire

//--- logic/memReqPkg.sv
`default_nettype none

package memReqPkg;

    // byte count of one request, legal values 1, 2 and 4
    typedef logic [2:0] lenT;

    // data cache access direction
    typedef logic lsT;

    localparam lsT lsLoad  = 1'b0;
    localparam lsT lsStore = 1'b1;

    // instruction fetch always reads a whole word
    localparam lenT fetchLen = 3'd4;

    // controller state, also tells the sequencer what kind of transfer runs
    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlStateT;

endpackage

`default_nettype wire

//--- logic/memReqIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memReqIf
    import memBusPkg::*, memReqPkg::*;
();

    // granted transfer, arbiter to sequencer
    logic      start;
    ctrlStateT kind;
    addrT      addr;
    lenT       len;
    wordT      wdata;

    // result, sequencer to arbiter
    logic      finish;
    wordT      rdata;

    // stall level, computed once by the arbiter
    logic      frozen;

    modport arbiter (
        output start, kind, addr, len, wdata, frozen,
        input  finish, rdata
    );

    modport sequencer (
        input  start, kind, addr, len, wdata, frozen,
        output finish, rdata
    );

endinterface

`default_nettype wire

//--- logic/accessArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module accessArbiter
    import memBusPkg::*, memReqPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic ioBufferFull,

    input  logic infEn,
    input  addrT infAddr,
    input  logic dcEn,
    input  addrT dcAddr,
    input  lsT   dcLs,
    input  lenT  dcLen,
    input  wordT dcData,

    output logic infDone,
    output wordT infInst,
    output logic bpEn,
    output wordT bpInst,
    output logic dcDone,
    output wordT dcRdata,

    output waitT infWait,
    output waitT dcWait,

    memReqIf.arbiter req
);

    ctrlStateT state;
    logic      accept;
    waitT      owner;

    assign req.frozen = !rdy || ioBufferFull;
    assign req.kind   = state;

    // data cache wins when both ask in the same cycle
    assign accept = (state == idle) && !req.frozen && (dcEn || infEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            req.start <= 1'b0;
        end else begin
            // start stays up through frozen cycles until the sequencer takes it
            if (accept) begin
                req.start <= 1'b1;
            end else if (!req.frozen) begin
                req.start <= 1'b0;
            end

            if (accept) begin
                if (dcEn) begin
                    state <= (dcLs == lsStore) ? writeData : readData;
                end else begin
                    state <= readInst;
                end
            end else if (req.finish) begin
                state <= idle;
            end
        end
    end

    // request fields, held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            if (dcEn) begin
                req.addr  <= dcAddr;
                req.len   <= dcLen;
                req.wdata <= dcData;
            end else begin
                req.addr  <= infAddr;
                req.len   <= fetchLen;
                req.wdata <= '0;
            end
        end
    end

    // result routing
    assign infDone = (state == readInst) && req.finish;
    assign bpEn    = infDone;
    assign infInst = infDone ? req.rdata : '0;
    assign bpInst  = infDone ? req.rdata : '0;

    assign dcDone  = (state == readData || state == writeData) && req.finish;
    assign dcRdata = (state == readData && req.finish) ? req.rdata : '0;

    always_comb begin
        case (state)
            readInst:  owner = waitFetch;
            readData:  owner = waitData;
            writeData: owner = waitData;
            default:   owner = waitFree;
        endcase
    end

    assign infWait = owner;
    assign dcWait  = owner;

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(infDone && dcDone));

    // only these lengths map to a byte sequence the CPU can issue
    dcLenLegal: assert property (@(posedge clk) disable iff (rst)
        (state == idle && dcEn) |-> (dcLen inside {3'd1, 3'd2, 3'd4}));

endmodule

`default_nettype wire

//--- logic/byteSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module byteSequencer
    import memBusPkg::*, memReqPkg::*;
(
    input  logic clk,
    input  logic rst,

    memReqIf.sequencer req,

    input  byteT memDin,
    output rwT   memRw,
    output addrT memAddr,
    output byteT memDout
);

    logic active;
    lenT  idx;
    addrT curAddr;
    addrT lastAddr;
    wordT asmWord;
    wordT fullWord;
    logic isWrite;
    logic issue;
    logic capture;

    assign isWrite = (req.kind == writeData);
    assign curAddr = req.addr + addrT'(idx);

    // one byte access per unfrozen cycle until len bytes are out
    assign issue = active && !req.frozen && (idx < req.len);

    // the byte addressed in the previous unfrozen cycle is on memDin now
    assign capture = active && !req.frozen && !isWrite && (idx != '0);

    // bytes enter at the top, so the last one lands in the high byte
    assign fullWord = {memDin, asmWord[wordW-1:byteW]};

    always_comb begin
        req.finish = 1'b0;
        if (active && !req.frozen) begin
            if (isWrite) begin
                // done in the last write cycle
                req.finish = (idx == lenT'(req.len - 3'd1));
            end else begin
                // done with the last returned byte
                req.finish = (idx == req.len);
            end
        end
    end

    // move the assembled bytes down and zero-fill above len
    assign req.rdata = fullWord >> (byteW * (bytesPerWord - int'(req.len)));

    // RAM side
    assign memRw   = (issue && isWrite) ? memWrite : memRead;
    assign memAddr = issue ? curAddr : lastAddr;
    assign memDout = req.wdata[idx[1:0]*byteW +: byteW];

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            idx      <= '0;
            lastAddr <= '0;
        end else if (!req.frozen) begin
            if (req.start) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (req.finish) begin
                active <= 1'b0;
            end

            if (issue) begin
                idx <= lenT'(idx + 3'd1);
            end

            // replayed while frozen so the byte in flight survives
            if (issue && !isWrite) begin
                lastAddr <= curAddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!req.frozen) begin
            if (req.start) begin
                asmWord <= '0;
            end else if (capture) begin
                asmWord <= fullWord;
            end
        end
    end

    noWriteFrozen: assert property (@(posedge clk) disable iff (rst)
        req.frozen |-> (memRw == memRead));

    idxInRange: assert property (@(posedge clk) disable iff (rst)
        active |-> (idx <= req.len));

endmodule

`default_nettype wire

//--- logic/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl
    import memBusPkg::*, memReqPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic ioBufferFull,

    // byte-wide RAM
    input  byteT memDin,
    output rwT   memRw,
    output addrT memAddr,
    output byteT memDout,

    // instruction fetch and branch predictor
    input  logic infEn,
    input  addrT infAddr,
    output logic infDone,
    output wordT infInst,
    output logic bpEn,
    output wordT bpInst,

    // data cache
    input  logic dcEn,
    input  lsT   dcLs,
    input  lenT  dcLen,
    input  wordT dcData,
    input  addrT dcAddr,
    output logic dcDone,
    output wordT dcRdata,

    // RAM owner
    output waitT infWait,
    output waitT dcWait
);

    memReqIf reqBus ();

    accessArbiter arb (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .infEn        (infEn),
        .infAddr      (infAddr),
        .dcEn         (dcEn),
        .dcAddr       (dcAddr),
        .dcLs         (dcLs),
        .dcLen        (dcLen),
        .dcData       (dcData),
        .infDone      (infDone),
        .infInst      (infInst),
        .bpEn         (bpEn),
        .bpInst       (bpInst),
        .dcDone       (dcDone),
        .dcRdata      (dcRdata),
        .infWait      (infWait),
        .dcWait       (dcWait),
        .req          (reqBus.arbiter)
    );

    byteSequencer seq (
        .clk     (clk),
        .rst     (rst),
        .req     (reqBus.sequencer),
        .memDin  (memDin),
        .memRw   (memRw),
        .memAddr (memAddr),
        .memDout (memDout)
    );

endmodule

`default_nettype wire

//--- verif/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

module ramModel
    import memBusPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic frozen,
    input  rwT   memRw,
    input  addrT memAddr,
    input  byteT memDout,
    output byteT memDin
);

    // 64 KiB, upper address bits ignored
    byteT mem [0:65535];

    // expected contents, kept by the testbench
    byteT shadow [0:65535];

    int frozenWrites = 0;

    // read data shows up one cycle after the address
    always @(posedge clk) begin
        memDin <= mem[memAddr[15:0]];
        if (memRw == memWrite) begin
            mem[memAddr[15:0]] <= memDout;
        end
    end

    noFrozenWrite: assert property (@(posedge clk) disable iff (rst)
        !(frozen && memRw == memWrite))
        else begin
            frozenWrites++;
            $display("RAM written at %h while the controller was frozen", $sampled(memAddr));
        end

endmodule

`default_nettype wire

//--- verif/memCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb
    import memBusPkg::*, memReqPkg::*;
();

    localparam int clkPeriod = 20;
    localparam int numTests = 24;
    // a store test runs two transfers plus idle gaps
    localparam int worstCycles = 16;
    localparam int freezeBudget = 40;
    localparam int doneLimit = 200;

    logic clk, rst, rdy, ioBufferFull;
    logic infEn, infDone, bpEn, dcEn, dcDone;
    byteT memDin, memDout;
    rwT   memRw;
    addrT memAddr, infAddr, dcAddr;
    wordT infInst, bpInst, dcData, dcRdata;
    lsT   dcLs;
    lenT  dcLen;
    waitT infWait, dcWait;

    integer seed = 84624;
    string  testName = "none";
    int     errCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    logic   idleCheck = 1'b0;
    logic   freezeOn = 1'b0;
    logic   expLoad = 1'b0;
    waitT   expOwner = waitFree;
    wordT   expInst = '0;
    wordT   expData = '0;

    memCtrl memCtrl_i (.*);

    ramModel ram (
        .clk     (clk),
        .rst     (rst),
        .frozen  (!rdy || ioBufferFull),
        .memRw   (memRw),
        .memAddr (memAddr),
        .memDout (memDout),
        .memDin  (memDin)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // random stall levels about one cycle in eight each
    always @(posedge clk) begin
        rdy          <= !freezeOn || ($random(seed) % 8 != 0);
        ioBufferFull <= freezeOn && ($random(seed) % 8 == 0);
    end

    resetQuiet: assert property (@(posedge clk) idleCheck |->
        (!infDone && !dcDone && !bpEn && memRw == memRead
         && infWait == waitFree && dcWait == waitFree))
        else begin
            errCount++;
            $display("%s: outputs left their idle values after reset", testName);
        end

    fetchWord: assert property (@(posedge clk) disable iff (rst)
        infDone |-> (infInst == expInst && bpInst == expInst))
        else begin
            errCount++;
            $display("MISMATCH %s expected %h actual %h / %h", testName, expInst,
                     $sampled(infInst), $sampled(bpInst));
        end

    bpPulse: assert property (@(posedge clk) disable iff (rst) bpEn == infDone)
        else begin
            errCount++;
            $display("%s: bpEn did not pulse together with infDone", testName);
        end

    loadWord: assert property (@(posedge clk) disable iff (rst)
        (dcDone && expLoad) |-> dcRdata == expData)
        else begin
            errCount++;
            $display("MISMATCH %s expected %h actual %h", testName, expData, $sampled(dcRdata));
        end

    // owner shown from the accepting edge until done
    ownerCodes: assert property (@(posedge clk) disable iff (rst)
        infWait == expOwner && dcWait == expOwner)
        else begin
            errCount++;
            $display("MISMATCH %s owner expected %h actual %h / %h", testName,
                     $sampled(expOwner), $sampled(infWait), $sampled(dcWait));
        end

    function automatic int errTotal();
        return errCount + ram.frozenWrites;
    endfunction

    function automatic addrT randAddr();
        return addrT'($random(seed)) & 32'h0000_ffef;
    endfunction

    // little-endian bytes with zeros above len
    function automatic wordT wordAt(input addrT addr, input lenT len);
        wordT w;
        int i;
        w = '0;
        for (i = 0; i < int'(len); i++) begin
            w[8*i +: 8] = ram.shadow[16'(addr + addrT'(i))];
        end
        return w;
    endfunction

    // finds the accepting edge and counts cycles and stalls up to done
    task automatic waitDone(input logic forData, input int baseLat);
        int lat;
        int stalls;
        int guard;
        logic accepted;
        logic seen;
        lat = 0;
        stalls = 0;
        accepted = 1'b0;
        seen = 1'b0;
        for (guard = 0; guard < doneLimit && !seen; guard++) begin
            @(posedge clk);
            if (accepted) begin
                lat++;
                stalls += (!rdy || ioBufferFull) ? 1 : 0;
                seen = forData ? dcDone : infDone;
                if (forData ? infDone : dcDone) begin
                    errCount++;
                    $display("%s: done pulsed for the other requester", testName);
                end
            end else begin
                accepted = rdy && !ioBufferFull;
                if (accepted) begin
                    expOwner = forData ? waitData : waitFetch;
                end
            end
        end
        expOwner = waitFree;
        if (!seen) begin
            errCount++;
            $display("%s: no done pulse within %0d cycles", testName, doneLimit);
        end
        latency: assert (!seen || lat == baseLat + stalls) else begin
            errCount++;
            $display("MISMATCH %s latency expected %0d actual %0d", testName,
                     baseLat + stalls, lat);
        end
        if (forData) begin
            dcEn <= 1'b0;
        end else begin
            infEn <= 1'b0;
        end
    endtask

    task automatic dataReq(input lsT ls, input lenT len, input addrT addr, input wordT data);
        dcLs   <= ls;
        dcLen  <= len;
        dcAddr <= addr;
        dcData <= data;
        dcEn   <= 1'b1;
        expLoad = (ls == lsLoad);
        expData = wordAt(addr, len);
        waitDone(1'b1, (ls == lsLoad) ? int'(len) + 2 : int'(len) + 1);
    endtask

    task automatic fetchReq(input addrT addr);
        infAddr <= addr;
        infEn   <= 1'b1;
        expInst = wordAt(addr, fetchLen);
        waitDone(1'b0, 6);
    endtask

    // store and compare the bytes around it before reading the whole word back
    task automatic storeCheck(input lenT len, input addrT addr, input wordT data);
        int i;
        addrT a;
        dataReq(lsStore, len, addr, data);
        for (i = 0; i < int'(len); i++) begin
            ram.shadow[16'(addr + addrT'(i))] = data[8*i +: 8];
        end
        @(posedge clk);
        for (a = addr - 4; a != addr + 8; a++) begin
            storeBytes: assert (ram.mem[16'(a)] == ram.shadow[16'(a)]) else begin
                errCount++;
                $display("MISMATCH %s byte %h expected %h actual %h", testName, a,
                         ram.shadow[16'(a)], ram.mem[16'(a)]);
            end
        end
        dataReq(lsLoad, 3'd4, addr, '0);
    endtask

    task automatic bothReq(input addrT fetchAddr, input addrT dataAddr, input lenT len);
        infAddr <= fetchAddr;
        infEn   <= 1'b1;
        expInst = wordAt(fetchAddr, fetchLen);
        dataReq(lsLoad, len, dataAddr, '0);
        waitDone(1'b0, 6);
    endtask

    task automatic endTest(input int errsBefore);
        @(posedge clk);
        if (errTotal() == errsBefore) begin
            passCount++;
            $display("test %s passed", testName);
        end else begin
            failCount++;
            $display("test %s failed", testName);
        end
    endtask

    task automatic oneTest(input string name, input int op, input lenT len);
        int errs;
        testName = name;
        errs = errTotal();
        case (op)
            0: fetchReq(randAddr());
            1: dataReq(lsLoad, len, randAddr(), '0);
            2: storeCheck(len, randAddr(), wordT'($random(seed)));
            default: bothReq(randAddr(), randAddr(), len);
        endcase
        endTest(errs);
    endtask

    initial begin
        int i;
        int errs;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        infEn = 1'b0;
        infAddr = '0;
        dcEn = 1'b0;
        dcLs = lsLoad;
        dcLen = 3'd1;
        dcData = '0;
        dcAddr = '0;
        for (i = 0; i < 65536; i++) begin
            ram.mem[i] = byteT'($random(seed));
            ram.shadow[i] = ram.mem[i];
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        testName = "resetIdle";
        errs = errTotal();
        idleCheck = 1'b1;
        repeat (4) @(posedge clk);
        idleCheck = 1'b0;
        endTest(errs);

        for (i = 0; i < 4; i++) begin
            oneTest($sformatf("fetch%0d", i), 0, fetchLen);
        end
        for (i = 0; i < 6; i++) begin
            oneTest($sformatf("load%0d", i), 1, lenT'(3'd1 << (i % 3)));
        end
        for (i = 0; i < 3; i++) begin
            oneTest($sformatf("store%0d", i), 2, lenT'(3'd1 << i));
        end
        for (i = 0; i < 2; i++) begin
            oneTest($sformatf("both%0d", i), 3, lenT'(3'd2 << i));
        end
        freezeOn <= 1'b1;
        for (i = 0; i < 8; i++) begin
            oneTest($sformatf("frozen%0d", i), $unsigned($random(seed)) % 3,
                    lenT'(3'd1 << ($unsigned($random(seed)) % 3)));
        end
        freezeOn <= 1'b0;

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && errTotal() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #((numTests * (worstCycles + freezeBudget) + 100) * clkPeriod);
        $display("watchdog: run did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- memCtrl.f
logic/memBusPkg.sv
logic/memReqPkg.sv
logic/memReqIf.sv
logic/accessArbiter.sv
logic/byteSequencer.sv
logic/memCtrl.sv
verif/ramModel.sv
verif/memCtrlTb.sv
